// File: build.f
+incdir+common
common/rv_pkg.sv
common/mem_port_if.sv
hdl/main_decoder.sv
core/reg_file.sv
core/rv_core.sv
hdl/mem_arbiter.sv
hdl/unified_mem.sv
hdl/rv_top.sv
sim/rv_checker.sv
sim/tb_rv_top.sv

// File: build.sh
#!/usr/bin/env bash
# builds and runs the rv_top testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal -f build.f --top-module tb_rv_top -o tb_rv_top; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

// File: sim/tb_rv_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module tb_rv_top;

    localparam int N_PROG    = 34;
    localparam int N_WRITES  = 26;     // register writes along the taken path
    localparam int LIMIT     = 200;    // cycles per handshake phase
    localparam int RUN_LIMIT = 20000;
    localparam logic [`XLEN-1:0] PRELOAD_ADDR = 32'h0000_0440;

    logic             clk;
    logic             rst_n;
    logic             core_run;
    logic             host_req;
    logic             host_we;
    logic [`XLEN-1:0] host_addr;
    logic [`XLEN-1:0] host_wdata;
    logic             host_ack;
    logic [`XLEN-1:0] host_rdata;
    logic             rf_we;
    logic [4:0]       rf_waddr;
    logic [`XLEN-1:0] rf_wdata;
    int               wb_count;
    int               err_count;
    int               timeouts;
    int               count_errs;
    integer           seed;
    logic [`XLEN-1:0] prog [N_PROG];
    logic [`XLEN-1:0] rnd [10];

    rv_top i_rv_top (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .core_run_i   (core_run),
        .host_req_i   (host_req),
        .host_we_i    (host_we),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_ack_o   (host_ack),
        .host_rdata_o (host_rdata),
        .rf_we_o      (rf_we),
        .rf_waddr_o   (rf_waddr),
        .rf_wdata_o   (rf_wdata)
    );

    rv_checker u_rv_checker (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .rf_we_i      (rf_we),
        .rf_waddr_i   (rf_waddr),
        .rf_wdata_i   (rf_wdata),
        .host_ack_i   (host_ack),
        .host_we_i    (host_we),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_rdata_i (host_rdata),
        .wb_count_o   (wb_count),
        .err_count_o  (err_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input int rs1,
                                           input logic [2:0] f3, input int rd,
                                           input logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input int rs2, input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    // beq only
    function automatic logic [31:0] b_type(input logic [12:0] imm, input int rs2, input int rs1);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'b000, imm[4:1], imm[11],
                rv_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), rv_pkg::OP_JAL};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input int rd);
        return {imm, 5'(rd), rv_pkg::OP_LUI};
    endfunction

    task automatic build_program();
        for (int i = 0; i < 10; i++) begin
            rnd[i] = $random(seed);
        end
        prog[0]  = u_type(rnd[0][31:12], 1);
        prog[1]  = i_type(rnd[1][11:0], 0, 3'b000, 2, rv_pkg::OP_IMM);
        prog[2]  = i_type(rnd[2][11:0], 1, 3'b000, 3, rv_pkg::OP_IMM);
        prog[3]  = r_type(7'h00, 3, 2, 3'b000, 4);    // add
        prog[4]  = r_type(7'h20, 2, 4, 3'b000, 5);    // sub
        prog[5]  = r_type(7'h00, 3, 4, 3'b111, 6);
        prog[6]  = r_type(7'h00, 2, 4, 3'b110, 7);
        prog[7]  = r_type(7'h00, 5, 7, 3'b100, 8);
        prog[8]  = r_type(7'h00, 4, 5, 3'b010, 9);    // slt
        prog[9]  = r_type(7'h00, 2, 4, 3'b001, 10);
        prog[10] = r_type(7'h00, 2, 4, 3'b101, 11);
        prog[11] = i_type(rnd[3][11:0], 5, 3'b010, 12, rv_pkg::OP_IMM);
        prog[12] = i_type(rnd[4][11:0], 4, 3'b100, 13, rv_pkg::OP_IMM);
        prog[13] = i_type(rnd[5][11:0], 4, 3'b110, 14, rv_pkg::OP_IMM);
        prog[14] = i_type(rnd[6][11:0], 4, 3'b111, 15, rv_pkg::OP_IMM);
        prog[15] = i_type({7'b0, rnd[7][4:0]}, 4, 3'b001, 16, rv_pkg::OP_IMM);
        prog[16] = i_type({7'b0, rnd[8][4:0]}, 4, 3'b101, 17, rv_pkg::OP_IMM);
        prog[17] = i_type(12'h400, 0, 3'b000, 20, rv_pkg::OP_IMM); // data base
        prog[18] = s_type(12'd0, 4, 20);
        prog[19] = s_type(12'd4, 8, 20);
        prog[20] = i_type(12'd0, 20, 3'b010, 21, rv_pkg::OP_LOAD);
        prog[21] = i_type(12'd4, 20, 3'b010, 22, rv_pkg::OP_LOAD);
        prog[22] = i_type(12'd64, 20, 3'b010, 23, rv_pkg::OP_LOAD); // host preloaded
        prog[23] = b_type(13'd8, 4, 21);    // always taken
        prog[24] = i_type(12'd1, 0, 3'b000, 24, rv_pkg::OP_IMM);
        prog[25] = i_type(12'd2, 0, 3'b000, 25, rv_pkg::OP_IMM);
        prog[26] = b_type(13'd8, 0, 25);    // never taken
        prog[27] = j_type(21'd8, 26);
        prog[28] = i_type(12'd3, 0, 3'b000, 27, rv_pkg::OP_IMM);
        prog[29] = i_type(12'd128, 0, 3'b000, 28, rv_pkg::OP_IMM);
        prog[30] = i_type(12'd0, 28, 3'b000, 29, rv_pkg::OP_JALR); // to word 32
        prog[31] = i_type(12'd5, 0, 3'b000, 30, rv_pkg::OP_IMM);
        prog[32] = r_type(7'h00, 26, 29, 3'b000, 31);
        prog[33] = j_type(21'd0, 0);        // park here
    endtask

    // one complete four-phase host transfer
    task automatic host_access(input logic we, input logic [`XLEN-1:0] addr,
                               input logic [`XLEN-1:0] wdata);
        int n;
        @(posedge clk);
        #1;
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!host_ack && n < LIMIT);
        if (!host_ack) begin
            $display("host access to %08h got no ack within %0d cycles", addr, LIMIT);
            timeouts++;
        end
        #1;
        host_req = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (host_ack && n < LIMIT);
        if (host_ack) begin
            $display("host ack at %08h never dropped after req fell", addr);
            timeouts++;
        end
    endtask

    initial begin
        int n;
        rst_n      = 1'b0;
        core_run   = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        timeouts   = 0;
        count_errs = 0;
        seed       = 56;
        build_program();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // load with the core held, then read back
        for (int i = 0; i < N_PROG; i++) begin
            host_access(1'b1, 32'(i * 4), prog[i]);
        end
        host_access(1'b1, PRELOAD_ADDR, rnd[9]);
        for (int i = 0; i < N_PROG; i++) begin
            host_access(1'b0, 32'(i * 4), '0);
        end
        host_access(1'b0, PRELOAD_ADDR, '0);

        @(posedge clk);
        #1;
        core_run = 1'b1;

        // host reads now compete with fetch and data traffic
        for (int i = 0; i < N_PROG; i++) begin
            host_access(1'b0, 32'(i * 4), '0);
        end

        n = 0;
        while (wb_count < N_WRITES && n < RUN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (wb_count < N_WRITES) begin
            $display("timed out waiting for register writes, %0d of %0d arrived",
                     wb_count, N_WRITES);
            timeouts++;
        end
        repeat (100) @(posedge clk);  // core parks in its jal loop
        if (wb_count != N_WRITES) begin
            $display("expected %0d register writes but saw %0d", N_WRITES, wb_count);
            count_errs++;
        end

        $display("mismatches %0d, timeouts %0d, write count errors %0d, writes %0d of %0d",
                 err_count, timeouts, count_errs, wb_count, N_WRITES);
        if (err_count == 0 && timeouts == 0 && count_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/rv_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module rv_checker (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,
    input  wire logic             rf_we_i,
    input  wire logic [4:0]       rf_waddr_i,
    input  wire logic [`XLEN-1:0] rf_wdata_i,
    input  wire logic             host_ack_i,
    input  wire logic             host_we_i,
    input  wire logic [`XLEN-1:0] host_addr_i,
    input  wire logic [`XLEN-1:0] host_wdata_i,
    input  wire logic [`XLEN-1:0] host_rdata_i,
    output int                    wb_count_o,
    output int                    err_count_o
);

    localparam int AW = $clog2(`MEM_WORDS);

    logic [`XLEN-1:0] mem_model [int];  // sparse, keyed by word index
    logic [`XLEN-1:0] iss_regs [32];
    logic [`XLEN-1:0] iss_pc;
    logic             ack_q;
    logic [4:0]       exp_rd;
    logic [`XLEN-1:0] exp_val;
    bit               found;
    int               writes;
    int               errs;

    function automatic int word_key(input logic [`XLEN-1:0] addr);
        return int'(addr[AW+1:2]);
    endfunction

    function automatic logic [`XLEN-1:0] read_word(input logic [`XLEN-1:0] addr);
        if (mem_model.exists(word_key(addr))) begin
            return mem_model[word_key(addr)];
        end
        return '0;
    endfunction

    // rv32i integer ops by funct3
    function automatic logic [`XLEN-1:0] alu_ref(input logic [2:0] f3, input logic [31:0] a,
                                                 input logic [31:0] b, input logic sub);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    // steps until the next write to a nonzero register
    function automatic bit rv_iss(output logic [4:0] rd, output logic [`XLEN-1:0] val);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] res;
        logic [31:0] nxt;
        bit          wr;
        rd  = '0;
        val = '0;
        for (int step = 0; step < 64; step++) begin
            ins   = read_word(iss_pc);
            a     = iss_regs[ins[19:15]];
            b     = iss_regs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            nxt   = iss_pc + 32'd4;
            res   = '0;
            wr    = 1'b1;
            case (ins[6:0])
                rv_pkg::OP_LOAD:  res = read_word(a + imm_i);
                rv_pkg::OP_STORE: begin
                    mem_model[word_key(a + imm_s)] = b;
                    wr = 1'b0;
                end
                rv_pkg::OP_BRANCH: begin
                    if (a == b) nxt = iss_pc + imm_b;
                    wr = 1'b0;
                end
                rv_pkg::OP_IMM:   res = alu_ref(ins[14:12], a, imm_i, 1'b0);
                rv_pkg::OP_JAL: begin
                    res = iss_pc + 32'd4;
                    nxt = iss_pc + imm_j;
                end
                rv_pkg::OP_JALR: begin
                    res = iss_pc + 32'd4;
                    nxt = (a + imm_i) & ~32'd1; // target from the old rs1
                end
                rv_pkg::OP_LUI:   res = {ins[31:12], 12'b0};
                default:          res = alu_ref(ins[14:12], a, b, ins[30]); // r-type
            endcase
            iss_pc = nxt;
            if (wr && ins[11:7] != 5'd0) begin
                iss_regs[ins[11:7]] = res;
                rd  = ins[11:7];
                val = res;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            iss_pc = `RESET_PC;
            for (int i = 0; i < 32; i++) begin
                iss_regs[i] = '0;
            end
            ack_q  = 1'b0;
            writes = 0;
            errs   = 0;
        end else begin
            // host port, one look per handshake at the ack edge
            if (host_ack_i && !ack_q) begin
                if (host_we_i) begin
                    mem_model[word_key(host_addr_i)] = host_wdata_i;
                end else if (host_rdata_i !== read_word(host_addr_i)) begin
                    $display("FAIL host_rdata_o at %08h: expected %08h, got %08h",
                             host_addr_i, read_word(host_addr_i), host_rdata_i);
                    errs++;
                end
            end
            ack_q = host_ack_i;

            if (rf_we_i) begin
                writes++;
                found = rv_iss(exp_rd, exp_val);
                if (!found) begin
                    $display("register write to x%0d arrived after the program stopped writing",
                             rf_waddr_i);
                    errs++;
                end else begin
                    if (rf_waddr_i !== exp_rd) begin
                        $display("FAIL rf_waddr_o: expected %02h, got %02h", exp_rd, rf_waddr_i);
                        errs++;
                    end
                    if (rf_wdata_i !== exp_val) begin
                        $display("FAIL rf_wdata_o: expected %08h, got %08h", exp_val, rf_wdata_i);
                        errs++;
                    end
                end
            end
        end
        wb_count_o  <= writes;
        err_count_o <= errs;
    end

endmodule

`default_nettype wire

// File: hdl/rv_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module rv_top (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,
    input  wire logic             core_run_i,
    input  wire logic             host_req_i,
    input  wire logic             host_we_i,
    input  wire logic [`XLEN-1:0] host_addr_i,
    input  wire logic [`XLEN-1:0] host_wdata_i,
    output logic                  host_ack_o,
    output logic      [`XLEN-1:0] host_rdata_o,
    output logic                  rf_we_o,
    output logic      [4:0]       rf_waddr_o,
    output logic      [`XLEN-1:0] rf_wdata_o
);

    mem_port_if ifetch_bus ();
    mem_port_if dmem_bus ();
    mem_port_if host_bus ();
    mem_port_if mem_bus ();

    // host pins onto its own port
    assign host_bus.req   = host_req_i;
    assign host_bus.we    = host_we_i;
    assign host_bus.addr  = host_addr_i;
    assign host_bus.wdata = host_wdata_i;
    assign host_ack_o     = host_bus.ack;
    assign host_rdata_o   = host_bus.rdata;

    rv_core u_rv_core (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .run_i      (core_run_i),
        .ifetch     (ifetch_bus.requester),
        .dmem       (dmem_bus.requester),
        .rf_we_o    (rf_we_o),
        .rf_waddr_o (rf_waddr_o),
        .rf_wdata_o (rf_wdata_o)
    );

    mem_arbiter u_mem_arbiter (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .ifetch_s (ifetch_bus.server),
        .dmem_s   (dmem_bus.server),
        .host_s   (host_bus.server),
        .mem_m    (mem_bus.requester)
    );

    unified_mem u_unified_mem (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .port    (mem_bus.server)
    );

endmodule

`default_nettype wire

// File: hdl/unified_mem.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module unified_mem (
    input  wire logic  clk_i,
    input  wire logic  rst_n_i,
    mem_port_if.server port
);

    localparam int AW = $clog2(`MEM_WORDS);

    rv_pkg::mem_state_e state_q;
    logic [`XLEN-1:0]   mem [`MEM_WORDS];
    logic [`XLEN-1:0]   rdata_q;
    logic [AW-1:0]      idx;

    assign idx = port.addr[AW+1:2];  // word address

    // ack high while in REQ, one cycle behind req on both edges
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= rv_pkg::IDLE;
        end else if (state_q == rv_pkg::IDLE) begin
            if (port.req) state_q <= rv_pkg::REQ;
        end else if (!port.req) begin
            state_q <= rv_pkg::IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == rv_pkg::IDLE && port.req) begin
            if (port.we) begin
                mem[idx] <= port.wdata;
            end
            rdata_q <= mem[idx];  // old word on a write
        end
    end

    assign port.ack   = (state_q == rv_pkg::REQ);
    assign port.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hdl/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    mem_port_if.server    ifetch_s,
    mem_port_if.server    dmem_s,
    mem_port_if.server    host_s,
    mem_port_if.requester mem_m
);

    rv_pkg::mem_state_e state_q;
    logic [1:0]         gnt_q;   // also the round-robin pointer once released
    logic [2:0]         req_vec;
    logic               busy;
    logic               sel_req;

    // first requester after the last granted one
    function automatic logic [1:0] next_grant(input logic [2:0] reqs, input logic [1:0] last);
        int         idx;
        logic [1:0] pick;
        pick = last;
        for (int k = 3; k >= 1; k--) begin
            idx = (int'(last) + k) % 3;
            if (reqs[idx]) begin
                pick = 2'(idx);
            end
        end
        return pick;
    endfunction

    assign req_vec = {host_s.req, dmem_s.req, ifetch_s.req};
    assign busy    = (state_q != rv_pkg::IDLE);
    assign sel_req = req_vec[gnt_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= rv_pkg::IDLE;
            gnt_q   <= 2'd2;  // ifetch goes first
        end else begin
            case (state_q)
                rv_pkg::IDLE: if (|req_vec) begin
                    gnt_q   <= next_grant(req_vec, gnt_q);
                    state_q <= rv_pkg::REQ;
                end
                rv_pkg::REQ: if (!sel_req) state_q <= rv_pkg::RELEASE;
                default:     if (!mem_m.ack) state_q <= rv_pkg::IDLE;
            endcase
        end
    end

    always_comb begin
        case (gnt_q)
            2'd0: begin
                mem_m.we    = ifetch_s.we;
                mem_m.addr  = ifetch_s.addr;
                mem_m.wdata = ifetch_s.wdata;
            end
            2'd1: begin
                mem_m.we    = dmem_s.we;
                mem_m.addr  = dmem_s.addr;
                mem_m.wdata = dmem_s.wdata;
            end
            default: begin
                mem_m.we    = host_s.we;
                mem_m.addr  = host_s.addr;
                mem_m.wdata = host_s.wdata;
            end
        endcase
    end

    assign mem_m.req = busy && sel_req;

    // ports without the grant see ack low and wait
    assign ifetch_s.ack = busy && (gnt_q == 2'd0) && mem_m.ack;
    assign dmem_s.ack   = busy && (gnt_q == 2'd1) && mem_m.ack;
    assign host_s.ack   = busy && (gnt_q == 2'd2) && mem_m.ack;

    assign ifetch_s.rdata = mem_m.rdata;
    assign dmem_s.rdata   = mem_m.rdata;
    assign host_s.rdata   = mem_m.rdata;

endmodule

`default_nettype wire

// File: core/rv_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module rv_core (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,
    input  wire logic             run_i,
    mem_port_if.requester         ifetch,
    mem_port_if.requester         dmem,
    output logic                  rf_we_o,
    output logic      [4:0]       rf_waddr_o,
    output logic      [`XLEN-1:0] rf_wdata_o
);

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        WB
    } phase_e;

    phase_e             phase_q;
    rv_pkg::mem_state_e if_st_q;
    rv_pkg::mem_state_e dm_st_q;
    logic [`XLEN-1:0]   pc_q;
    logic [`XLEN-1:0]   pc_next_q;
    logic [`XLEN-1:0]   instr_q;
    logic [`XLEN-1:0]   alu_q;
    logic [`XLEN-1:0]   load_q;
    rv_pkg::ctrl_t      ctrl;
    logic [`XLEN-1:0]   rd1;
    logic [`XLEN-1:0]   rd2;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   src_b;
    logic [`XLEN-1:0]   alu_res;

    main_decoder u_main_decoder (
        .op_i   (instr_q[6:0]),
        .ctrl_o (ctrl)
    );

    reg_file u_reg_file (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ra1_i   (instr_q[19:15]),
        .ra2_i   (instr_q[24:20]),
        .rd1_o   (rd1),
        .rd2_o   (rd2),
        .we_i    (rf_we_o),
        .wa_i    (rf_waddr_o),
        .wd_i    (rf_wdata_o)
    );

    always_comb begin
        case (ctrl.imm_src)
            rv_pkg::IMM_S: imm = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
            rv_pkg::IMM_B: imm = {{20{instr_q[31]}}, instr_q[7], instr_q[30:25],
                                  instr_q[11:8], 1'b0};
            rv_pkg::IMM_J: imm = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20],
                                  instr_q[30:21], 1'b0};
            rv_pkg::IMM_U: imm = {instr_q[31:12], 12'b0};
            default:       imm = {{20{instr_q[31]}}, instr_q[31:20]};
        endcase
    end

    assign src_b = ctrl.alu_src ? imm : rd2;

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::ALU_ADD:  alu_res = rd1 + src_b;
            rv_pkg::ALU_SUB:  alu_res = rd1 - src_b;
            rv_pkg::ALU_PASS: alu_res = src_b;
            default: begin
                case (instr_q[14:12])
                    // sub only for register operands, funct7 bit 5
                    3'b000:  alu_res = (!ctrl.alu_src && instr_q[30]) ? rd1 - src_b
                                                                       : rd1 + src_b;
                    3'b001:  alu_res = rd1 << src_b[4:0];
                    3'b010:  alu_res = {{(`XLEN-1){1'b0}}, $signed(rd1) < $signed(src_b)};
                    3'b100:  alu_res = rd1 ^ src_b;
                    3'b101:  alu_res = rd1 >> src_b[4:0]; // logical only
                    3'b110:  alu_res = rd1 | src_b;
                    3'b111:  alu_res = rd1 & src_b;
                    default: alu_res = rd1 + src_b;
                endcase
            end
        endcase
    end

    // datapath registers
    always_ff @(posedge clk_i) begin
        if (phase_q == FETCH && if_st_q == rv_pkg::REQ && ifetch.ack) begin
            instr_q <= ifetch.rdata;
        end
        if (phase_q == EXEC) begin
            alu_q <= alu_res;
            if (ctrl.jalr) begin
                pc_next_q <= {alu_res[`XLEN-1:1], 1'b0};
            end else if (ctrl.jump || (ctrl.branch && alu_res == '0)) begin
                pc_next_q <= pc_q + imm;
            end else begin
                pc_next_q <= pc_q + 4;
            end
        end
        if (phase_q == MEM && dm_st_q == rv_pkg::REQ && dmem.ack) begin
            load_q <= dmem.rdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            phase_q    <= FETCH;
            pc_q       <= `RESET_PC;
            if_st_q    <= rv_pkg::IDLE;
            dm_st_q    <= rv_pkg::IDLE;
            ifetch.req <= 1'b0;
            dmem.req   <= 1'b0;
        end else begin
            case (phase_q)
                FETCH: begin
                    case (if_st_q)
                        rv_pkg::IDLE: if (run_i) begin
                            ifetch.req <= 1'b1;
                            if_st_q    <= rv_pkg::REQ;
                        end
                        rv_pkg::REQ: if (ifetch.ack) begin
                            ifetch.req <= 1'b0;
                            if_st_q    <= rv_pkg::RELEASE;
                        end
                        default: if (!ifetch.ack) begin // wait for ack to fall
                            if_st_q <= rv_pkg::IDLE;
                            phase_q <= EXEC;
                        end
                    endcase
                end
                EXEC: phase_q <= ctrl.cache_enable ? MEM : WB;
                MEM: begin
                    case (dm_st_q)
                        rv_pkg::IDLE: begin
                            dmem.req <= 1'b1;
                            dm_st_q  <= rv_pkg::REQ;
                        end
                        rv_pkg::REQ: if (dmem.ack) begin
                            dmem.req <= 1'b0;
                            dm_st_q  <= rv_pkg::RELEASE;
                        end
                        default: if (!dmem.ack) begin
                            dm_st_q <= rv_pkg::IDLE;
                            phase_q <= WB;
                        end
                    endcase
                end
                default: begin
                    pc_q    <= pc_next_q;
                    phase_q <= FETCH;
                end
            endcase
        end
    end

    assign ifetch.addr  = pc_q;
    assign ifetch.we    = 1'b0;  // fetch only reads
    assign ifetch.wdata = '0;

    // payload stays stable for the whole MEM phase
    assign dmem.we    = ctrl.mem_write;
    assign dmem.addr  = alu_q;
    assign dmem.wdata = rd2;

    always_comb begin
        case (ctrl.result_src)
            rv_pkg::RES_MEM: rf_wdata_o = load_q;
            rv_pkg::RES_PC4: rf_wdata_o = pc_q + 4;
            rv_pkg::RES_IMM: rf_wdata_o = imm;
            default:         rf_wdata_o = alu_q;
        endcase
    end

    // writes to x0 are not reported
    assign rf_waddr_o = instr_q[11:7];
    assign rf_we_o    = (phase_q == WB) && ctrl.reg_write && (rf_waddr_o != 5'd0);

endmodule

`default_nettype wire

// File: core/reg_file.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

module reg_file (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,
    input  wire logic [4:0]       ra1_i,
    input  wire logic [4:0]       ra2_i,
    output logic      [`XLEN-1:0] rd1_o,
    output logic      [`XLEN-1:0] rd2_o,
    input  wire logic             we_i,
    input  wire logic [4:0]       wa_i,
    input  wire logic [`XLEN-1:0] wd_i
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wa_i != 5'd0)) begin
            regs[wa_i] <= wd_i;
        end
    end

    assign rd1_o = (ra1_i == 5'd0) ? '0 : regs[ra1_i]; // x0 hardwired
    assign rd2_o = (ra2_i == 5'd0) ? '0 : regs[ra2_i];

endmodule

`default_nettype wire

// File: hdl/main_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module main_decoder (
    input  wire logic [6:0] op_i,
    output rv_pkg::ctrl_t   ctrl_o
);

    always_comb begin
        // r-type values first, the case below overrides them
        ctrl_o.branch       = 1'b0;
        ctrl_o.jump         = 1'b0;
        ctrl_o.jalr         = 1'b0;
        ctrl_o.result_src   = rv_pkg::RES_ALU;
        ctrl_o.mem_write    = 1'b0;
        ctrl_o.alu_src      = 1'b0;
        ctrl_o.imm_src      = rv_pkg::IMM_I;
        ctrl_o.reg_write    = 1'b1;
        ctrl_o.alu_op       = rv_pkg::ALU_FUNCT;
        ctrl_o.cache_enable = 1'b0;

        case (op_i)
            rv_pkg::OP_LOAD: begin
                ctrl_o.alu_src      = 1'b1;
                ctrl_o.result_src   = rv_pkg::RES_MEM;
                ctrl_o.alu_op       = rv_pkg::ALU_ADD; // base plus offset
                ctrl_o.cache_enable = 1'b1;
            end

            rv_pkg::OP_STORE: begin
                ctrl_o.reg_write    = 1'b0;
                ctrl_o.imm_src      = rv_pkg::IMM_S;
                ctrl_o.alu_src      = 1'b1;
                ctrl_o.mem_write    = 1'b1;
                ctrl_o.alu_op       = rv_pkg::ALU_ADD;
                ctrl_o.cache_enable = 1'b1;
            end

            rv_pkg::OP_BRANCH: begin
                ctrl_o.reg_write = 1'b0;
                ctrl_o.imm_src   = rv_pkg::IMM_B;
                ctrl_o.branch    = 1'b1;
                ctrl_o.alu_op    = rv_pkg::ALU_SUB;  // zero flag means equal
            end

            rv_pkg::OP_IMM: begin
                ctrl_o.alu_src = 1'b1;
            end

            rv_pkg::OP_JAL: begin
                ctrl_o.imm_src    = rv_pkg::IMM_J;
                ctrl_o.result_src = rv_pkg::RES_PC4;
                ctrl_o.alu_op     = rv_pkg::ALU_ADD;
                ctrl_o.jump       = 1'b1;
            end

            // target is formed beside the alu
            rv_pkg::OP_JALR: begin
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.result_src = rv_pkg::RES_PC4;
                ctrl_o.jalr       = 1'b1;
            end

            rv_pkg::OP_LUI: begin
                ctrl_o.imm_src    = rv_pkg::IMM_U;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.result_src = rv_pkg::RES_IMM;
                ctrl_o.alu_op     = rv_pkg::ALU_PASS;
            end

            // r-type and unknown opcodes keep the defaults
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: common/mem_port_if.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_settings.svh"

// four-phase req/ack memory port
interface mem_port_if;

    logic             req;
    logic             we;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
    logic             ack;
    logic [`XLEN-1:0] rdata;  // valid while ack is high

    modport requester (
        output req, we, addr, wdata,
        input  ack, rdata
    );

    modport server (
        input  req, we, addr, wdata,
        output ack, rdata
    );

endinterface

`default_nettype wire

// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // opcodes known to the main decoder
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_IMM    = 7'b0010011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_J = 3'd3,
        IMM_U = 3'd4
    } imm_src_e;

    // writeback source
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2,
        RES_IMM = 2'd3
    } result_src_e;

    typedef enum logic [1:0] {
        ALU_ADD   = 2'd0,
        ALU_SUB   = 2'd1,
        ALU_FUNCT = 2'd2, // funct3/funct7 pick the op
        ALU_PASS  = 2'd3
    } alu_op_e;

    typedef struct packed {
        logic        branch;
        logic        jump;
        logic        jalr;
        result_src_e result_src;
        logic        mem_write;
        logic        alu_src;      // 1 selects the immediate
        imm_src_e    imm_src;
        logic        reg_write;
        alu_op_e     alu_op;
        logic        cache_enable; // data memory access
    } ctrl_t;

    // four-phase handshake progress
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE
    } mem_state_e;

endpackage

`default_nettype wire

// File: common/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define XLEN 32

// unified memory depth, in words
`define MEM_WORDS 1024

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
